//--- rtl/burstArbiter.sv
// Per-port address pointers and fixed-priority selection of the next memory burst
`timescale 1ns/1ps
`default_nettype none

`include "burstMem_defines.svh"

module burstArbiter (
    input  wire logic              CLK,
    input  wire logic              RESET_N,
    input  wire burstMemPkg::cntT  wrUsed   [`BM_NUM_WR],
    input  wire burstMemPkg::cntT  rdUsed   [`BM_NUM_RD],
    input  wire burstMemPkg::addrT wrStart  [`BM_NUM_WR],
    input  wire burstMemPkg::addrT wrMax    [`BM_NUM_WR],
    input  wire burstMemPkg::lenT  wrLength [`BM_NUM_WR],
    input  wire burstMemPkg::addrT rdStart  [`BM_NUM_RD],
    input  wire burstMemPkg::addrT rdMax    [`BM_NUM_RD],
    input  wire burstMemPkg::lenT  rdLength [`BM_NUM_RD],
    input  wire logic              wrLoad   [`BM_NUM_WR],
    input  wire logic              rdLoad   [`BM_NUM_RD],
    input  wire logic              done,        // Burst finished by sequencer
    output logic                   start,       // One-cycle launch pulse
    output burstMemPkg::addrT      burstAddr,
    output burstMemPkg::lenT       burstLen,
    output logic                   burstWrite,  // 1 = write side granted
    output logic                   grantPort    // Port index on granted side
);

    burstMemPkg::addrT wrPtr [`BM_NUM_WR];
    burstMemPkg::addrT rdPtr [`BM_NUM_RD];
    logic              busy;        // Between start and done
    logic              anyLoad;
    logic              pick;
    logic              pickWrite;
    logic              pickPort;
    logic              launch;

    // Advance by one burst or wrap to start when the next one would not fit
    function automatic burstMemPkg::addrT nextAddr(input burstMemPkg::addrT ptr,
                                                   input burstMemPkg::addrT maxAddr,
                                                   input burstMemPkg::lenT  len,
                                                   input burstMemPkg::addrT startAddr);
        burstMemPkg::addrT   step;
        logic [`BM_ADDR_W:0] nextEnd;   // Last word of the next burst, one bit wider
        step    = burstMemPkg::addrT'(len);
        nextEnd = {1'b0, ptr} + {len, 1'b0} - 1'b1;
        if (nextEnd <= {1'b0, maxAddr})
            return ptr + step;
        return startAddr;
    endfunction

    //============================================================
    // Eligibility and priority
    //============================================================
    always_comb
    begin
        anyLoad   = 1'b0;
        pick      = 1'b0;
        pickWrite = 1'b0;
        pickPort  = 1'b0;
        for (int i = 0; i < `BM_NUM_WR; i++)
            anyLoad = anyLoad | wrLoad[i];
        for (int i = 0; i < `BM_NUM_RD; i++)
            anyLoad = anyLoad | rdLoad[i];
        // Scan lowest priority first so higher ones overwrite
        for (int i = `BM_NUM_RD - 1; i >= 0; i--)
        begin
            if (rdLength[i] != '0 && rdUsed[i] < burstMemPkg::cntT'(rdLength[i]))
            begin
                pick      = 1'b1;
                pickWrite = 1'b0;
                pickPort  = 1'(i);
            end
        end
        for (int i = `BM_NUM_WR - 1; i >= 0; i--)
        begin
            if (wrLength[i] != '0 && wrUsed[i] >= burstMemPkg::cntT'(wrLength[i]))
            begin
                pick      = 1'b1;
                pickWrite = 1'b1;
                pickPort  = 1'(i);
            end
        end
    end

    assign launch = !busy && !anyLoad && pick;   // Only while idle

    //============================================================
    // Grant control
    //============================================================
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            start      <= 1'b0;
            busy       <= 1'b0;
            burstWrite <= 1'b0;
            grantPort  <= 1'b0;
        end
        else
        begin
            start <= launch;
            if (launch)
            begin
                busy       <= 1'b1;
                burstWrite <= pickWrite;
                grantPort  <= pickPort;
            end
            else if (done)
                busy <= 1'b0;                 // Next choice on following cycle
        end
    end

    // Burst descriptor held for the whole burst
    always_ff @(posedge CLK)
    begin
        if (launch)
        begin
            burstAddr <= pickWrite ? wrPtr[pickPort] : rdPtr[pickPort];
            burstLen  <= pickWrite ? wrLength[pickPort] : rdLength[pickPort];
        end
    end

    //============================================================
    // Address pointers
    //============================================================
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            for (int i = 0; i < `BM_NUM_WR; i++)
                wrPtr[i] <= wrStart[i];           // Captured at reset
            for (int i = 0; i < `BM_NUM_RD; i++)
                rdPtr[i] <= rdStart[i];
        end
        else
        begin
            for (int i = 0; i < `BM_NUM_WR; i++)
            begin
                if (wrLoad[i])
                    wrPtr[i] <= wrStart[i];
                else if (done && burstWrite && grantPort == 1'(i))
                    wrPtr[i] <= nextAddr(wrPtr[i], wrMax[i], wrLength[i], wrStart[i]);
            end
            for (int i = 0; i < `BM_NUM_RD; i++)
            begin
                if (rdLoad[i])
                    rdPtr[i] <= rdStart[i];
                else if (done && !burstWrite && grantPort == 1'(i))
                    rdPtr[i] <= nextAddr(rdPtr[i], rdMax[i], rdLength[i], rdStart[i]);
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/burstMemPkg.sv
// Shared word, address, length and count types for the burst memory controller
`default_nettype none

`include "burstMem_defines.svh"

package burstMemPkg;

    // One memory word
    typedef logic [`BM_DATA_W-1:0] dataT;

    // Word address into the shared memory
    typedef logic [`BM_ADDR_W-1:0] addrT;

    typedef logic [`BM_LEN_W-1:0]  lenT;    // Burst length in words
    typedef logic [`BM_CNT_W-1:0]  cntT;    // FIFO fill level

endpackage

`default_nettype wire

//--- rtl/burstMemTop.sv
// Top level of the multi-port burst memory controller, joins FIFOs, arbiter and RAM
`timescale 1ns/1ps
`default_nettype none

`include "burstMem_defines.svh"

module burstMemTop (
    input  wire logic              CLK,
    input  wire logic              RESET_N,
    // Write side
    input  wire burstMemPkg::dataT wrData   [`BM_NUM_WR],
    input  wire logic              wrPush   [`BM_NUM_WR],
    input  wire logic              wrLoad   [`BM_NUM_WR],
    input  wire burstMemPkg::addrT wrStart  [`BM_NUM_WR],
    input  wire burstMemPkg::addrT wrMax    [`BM_NUM_WR],
    input  wire burstMemPkg::lenT  wrLength [`BM_NUM_WR],
    output logic                   wrFull   [`BM_NUM_WR],
    // Read side
    input  wire logic              rdPop    [`BM_NUM_RD],
    input  wire logic              rdLoad   [`BM_NUM_RD],
    input  wire burstMemPkg::addrT rdStart  [`BM_NUM_RD],
    input  wire burstMemPkg::addrT rdMax    [`BM_NUM_RD],
    input  wire burstMemPkg::lenT  rdLength [`BM_NUM_RD],
    output burstMemPkg::dataT      rdData   [`BM_NUM_RD],
    output logic                   rdEmpty  [`BM_NUM_RD]
);

    burstMemPkg::cntT  wrUsed    [`BM_NUM_WR];
    burstMemPkg::cntT  rdUsed    [`BM_NUM_RD];
    burstMemPkg::dataT wrHead    [`BM_NUM_WR];   // Show-ahead heads
    burstMemPkg::addrT burstAddr;
    burstMemPkg::lenT  burstLen;
    burstMemPkg::addrT memAddr;
    burstMemPkg::dataT memRdData;
    logic              start;
    logic              done;
    logic              burstWrite;
    logic              grantPort;
    logic              seqPop;
    logic              seqPush;
    logic              memWrite;
    logic              memRead;

    //============================================================
    // Port FIFOs, strobes steered by the grant
    //============================================================
    for (genvar i = 0; i < `BM_NUM_WR; i++)
    begin : genWrFifo
        portFifo uWrFifo (
            .CLK(CLK), .RESET_N(RESET_N),
            .clear(wrLoad[i]),
            .push(wrPush[i]), .pushData(wrData[i]),
            .pop(seqPop && burstWrite && grantPort == 1'(i)),
            .popData(wrHead[i]), .used(wrUsed[i]),
            .full(wrFull[i]), .empty()
        );
    end

    for (genvar i = 0; i < `BM_NUM_RD; i++)
    begin : genRdFifo
        portFifo uRdFifo (
            .CLK(CLK), .RESET_N(RESET_N),
            .clear(rdLoad[i]),
            .push(seqPush && !burstWrite && grantPort == 1'(i)),
            .pushData(memRdData),                 // Shared memory read bus
            .pop(rdPop[i]),
            .popData(rdData[i]), .used(rdUsed[i]),
            .full(), .empty(rdEmpty[i])
        );
    end

    //============================================================
    // Arbiter, sequencer and memory
    //============================================================
    burstArbiter uArbiter (
        .CLK(CLK), .RESET_N(RESET_N),
        .wrUsed(wrUsed), .rdUsed(rdUsed),
        .wrStart(wrStart), .wrMax(wrMax), .wrLength(wrLength),
        .rdStart(rdStart), .rdMax(rdMax), .rdLength(rdLength),
        .wrLoad(wrLoad), .rdLoad(rdLoad), .done(done),
        .start(start), .burstAddr(burstAddr), .burstLen(burstLen),
        .burstWrite(burstWrite), .grantPort(grantPort)
    );

    burstSequencer uSequencer (
        .CLK(CLK), .RESET_N(RESET_N),
        .start(start), .burstAddr(burstAddr), .burstLen(burstLen),
        .burstWrite(burstWrite),
        .fifoPop(seqPop), .fifoPush(seqPush),
        .memWrite(memWrite), .memRead(memRead),
        .memAddr(memAddr), .done(done)
    );

    wordMemory uMemory (
        .CLK(CLK),
        .write(memWrite), .read(memRead), .addr(memAddr),
        .writeData(wrHead[grantPort]),            // Granted write FIFO head
        .readData(memRdData)
    );

endmodule

`default_nettype wire

//--- rtl/burstMem_defines.svh
// Width, depth and port-count macros shared by the package and every RTL block
`ifndef BURSTMEM_DEFINES_SVH
`define BURSTMEM_DEFINES_SVH

//============================================================
// Data path
//============================================================
`define BM_DATA_W      16   // Memory word width
`define BM_ADDR_W      8    // 256-word memory

//============================================================
// Bursts and FIFOs
//============================================================
`define BM_LEN_W       4    // Burst length field, max usable 8
`define BM_FIFO_DEPTH  16   // Words per port FIFO
`define BM_CNT_W       5    // Used count, holds 0..16

//============================================================
// Port counts
//============================================================
`define BM_NUM_WR      2    // Write ports
`define BM_NUM_RD      2    // Read ports

`endif

//--- rtl/burstSequencer.sv
// Beat counter that runs one burst between the granted FIFO and the memory
`timescale 1ns/1ps
`default_nettype none

module burstSequencer (
    input  wire logic              CLK,
    input  wire logic              RESET_N,
    input  wire logic              start,       // Launch pulse from arbiter
    input  wire burstMemPkg::addrT burstAddr,
    input  wire burstMemPkg::lenT  burstLen,
    input  wire logic              burstWrite,
    output logic                   fifoPop,     // Write FIFO pop, one per beat
    output logic                   fifoPush,    // Read FIFO push, lags read by one
    output logic                   memWrite,
    output logic                   memRead,
    output burstMemPkg::addrT      memAddr,
    output logic                   done         // One-cycle end of burst
);

    logic             active;      // Beats in progress
    logic             isWrite;
    burstMemPkg::lenT beatsLeft;
    logic             lastBeat;
    logic             readDly;     // memRead one cycle late
    logic             lastRead;    // Last read beat, delayed

    assign lastBeat = active && (beatsLeft == burstMemPkg::lenT'(1));
    assign memWrite = active && isWrite;
    assign memRead  = active && !isWrite;
    assign fifoPop  = memWrite;            // Same cycle as the write
    assign fifoPush = readDly;             // Memory data is ready now

    // Beat control
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            active    <= 1'b0;
            isWrite   <= 1'b0;
            beatsLeft <= '0;
            readDly   <= 1'b0;
            lastRead  <= 1'b0;
            done      <= 1'b0;
        end
        else
        begin
            readDly  <= memRead;
            lastRead <= lastBeat && !isWrite;
            done     <= (lastBeat && isWrite) || lastRead;  // Write: after last beat
            if (start)
            begin
                active    <= 1'b1;
                isWrite   <= burstWrite;
                beatsLeft <= burstLen;
            end
            else if (active)
            begin
                beatsLeft <= beatsLeft - 1'b1;
                if (lastBeat)
                    active <= 1'b0;
            end
        end
    end

    // Address steps once per beat
    always_ff @(posedge CLK)
    begin
        if (start)
            memAddr <= burstAddr;
        else if (active)
            memAddr <= memAddr + 1'b1;
    end

endmodule

`default_nettype wire

//--- rtl/portFifo.sv
// Single-clock show-ahead FIFO with fill count and synchronous clear for each port
`timescale 1ns/1ps
`default_nettype none

`include "burstMem_defines.svh"

module portFifo #(
    parameter int DEPTH = `BM_FIFO_DEPTH
) (
    input  wire logic              CLK,
    input  wire logic              RESET_N,
    input  wire logic              clear,     // Drops contents on port Load
    input  wire logic              push,
    input  wire burstMemPkg::dataT pushData,
    input  wire logic              pop,
    output burstMemPkg::dataT      popData,   // Head word while not empty
    output burstMemPkg::cntT       used,
    output logic                   full,
    output logic                   empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    burstMemPkg::dataT mem [DEPTH];
    logic [PTR_W-1:0]  wrPtr;
    logic [PTR_W-1:0]  rdPtr;
    logic              doPush;
    logic              doPop;

    assign full    = (used == burstMemPkg::cntT'(DEPTH));
    assign empty   = (used == '0);
    assign doPush  = push && !full;    // Ignored when full
    assign doPop   = pop && !empty;    // Ignored when empty
    assign popData = mem[rdPtr];       // Show-ahead head

    // Storage write
    always_ff @(posedge CLK)
    begin
        if (doPush && !clear)
            mem[wrPtr] <= pushData;
    end

    // Pointers and count
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            used  <= '0;
        end
        else if (clear)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            used  <= '0;
        end
        else
        begin
            if (doPush)
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            if (doPop)
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            if (doPush && !doPop)
                used <= used + 1'b1;
            else if (doPop && !doPush)
                used <= used - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/wordMemory.sv
// Single-port synchronous word RAM shared by all ports, one cycle of read latency
`timescale 1ns/1ps
`default_nettype none

module wordMemory (
    input  wire logic              CLK,
    input  wire logic              write,
    input  wire logic              read,
    input  wire burstMemPkg::addrT addr,
    input  wire burstMemPkg::dataT writeData,
    output burstMemPkg::dataT      readData     // Registered, valid cycle after read
);

    localparam int WORDS = 1 << $bits(burstMemPkg::addrT);

    burstMemPkg::dataT mem [WORDS];

    always_ff @(posedge CLK)
    begin
        if (write)
            mem[addr] <= writeData;
        if (read)
            readData <= mem[addr];
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build with Verilator, run the simulation, and fail when the log reports failure
verilator --binary --timing --assert --top-module burstMemTb -f vlog.f -o simv \
    && { ./obj_dir/simv > sim.log; cat sim.log; ! grep -q "Result: FAILED" sim.log \
         && grep -q "Result:" sim.log; } \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- testbench/burstMemTb.sv
// Random-stimulus testbench that run.sh builds from vlog.f to check burstMemTop against a model
`timescale 1ns/1ps
`default_nettype none

`include "burstMem_defines.svh"

module burstMemTb;

    localparam int TIMEOUT = 2000;   // Cycle limit for every wait
    localparam int QUIET   = 16;     // Idle cycles that count as drained

    logic              CLK;
    logic              RESET_N;
    burstMemPkg::dataT wrData   [`BM_NUM_WR];
    logic              wrPush   [`BM_NUM_WR];
    logic              wrLoad   [`BM_NUM_WR];
    burstMemPkg::addrT wrStart  [`BM_NUM_WR];
    burstMemPkg::addrT wrMax    [`BM_NUM_WR];
    burstMemPkg::lenT  wrLength [`BM_NUM_WR];
    logic              wrFull   [`BM_NUM_WR];
    logic              rdPop    [`BM_NUM_RD];
    logic              rdLoad   [`BM_NUM_RD];
    burstMemPkg::addrT rdStart  [`BM_NUM_RD];
    burstMemPkg::addrT rdMax    [`BM_NUM_RD];
    burstMemPkg::lenT  rdLength [`BM_NUM_RD];
    burstMemPkg::dataT rdData   [`BM_NUM_RD];
    logic              rdEmpty  [`BM_NUM_RD];

    integer seed;
    int     errors;
    int     checks;
    int     testErrors;      // Error count when the current test began

    //============================================================
    // Reference model state
    //============================================================
    burstMemPkg::dataT modelMem  [256];
    burstMemPkg::dataT pendWords [`BM_NUM_WR][16];   // Words waiting for a full burst
    int                pendCount [`BM_NUM_WR];
    int                wrPtrM    [`BM_NUM_WR];
    int                wrStartM  [`BM_NUM_WR];
    int                wrMaxM    [`BM_NUM_WR];
    int                wrLenM    [`BM_NUM_WR];
    int                rdPtrM    [`BM_NUM_RD];
    int                rdBeat    [`BM_NUM_RD];   // Word within current read burst
    int                rdStartM  [`BM_NUM_RD];
    int                rdMaxM    [`BM_NUM_RD];
    int                rdLenM    [`BM_NUM_RD];

    burstMemTop UUT (
        .CLK(CLK), .RESET_N(RESET_N),
        .wrData(wrData), .wrPush(wrPush), .wrLoad(wrLoad),
        .wrStart(wrStart), .wrMax(wrMax), .wrLength(wrLength), .wrFull(wrFull),
        .rdPop(rdPop), .rdLoad(rdLoad),
        .rdStart(rdStart), .rdMax(rdMax), .rdLength(rdLength),
        .rdData(rdData), .rdEmpty(rdEmpty)
    );

    always #2 CLK = ~CLK;    // 4 ns period

    // Next burst start or the window start when a whole burst no longer fits
    function automatic int advancePointer(input int ptr, input int len,
                                          input int startA, input int maxA);
        int next;
        next = ptr + len;
        if (next + len - 1 > maxA)
            return startA;
        return next;
    endfunction

    // Model side of a push that updates memory only once a full burst is queued
    function automatic void recordPush(input logic p, input burstMemPkg::dataT word);
        pendWords[p][burstMemPkg::lenT'(pendCount[p])] = word;
        pendCount[p]++;
        if (pendCount[p] == wrLenM[p])
        begin
            for (int k = 0; k < wrLenM[p]; k++)
                modelMem[burstMemPkg::addrT'(wrPtrM[p] + k)] = pendWords[p][burstMemPkg::lenT'(k)];
            wrPtrM[p]    = advancePointer(wrPtrM[p], wrLenM[p], wrStartM[p], wrMaxM[p]);
            pendCount[p] = 0;
        end
    endfunction

    //============================================================
    // Stimulus tasks
    //============================================================
    task automatic configWrite(input logic p, input int startA, input int maxA, input int len);
        @(posedge CLK);
        wrStart[p]  <= burstMemPkg::addrT'(startA);
        wrMax[p]    <= burstMemPkg::addrT'(maxA);
        wrLength[p] <= burstMemPkg::lenT'(len);
        wrLoad[p]   <= 1'b1;          // Clears FIFO and reloads pointer
        @(posedge CLK);
        wrLoad[p]    <= 1'b0;
        wrStartM[p]  = startA;
        wrMaxM[p]    = maxA;
        wrLenM[p]    = len;
        wrPtrM[p]    = startA;
        pendCount[p] = 0;             // Queued words are gone
    endtask

    task automatic configRead(input logic p, input int startA, input int maxA, input int len);
        @(posedge CLK);
        rdStart[p]  <= burstMemPkg::addrT'(startA);
        rdMax[p]    <= burstMemPkg::addrT'(maxA);
        rdLoad[p]   <= 1'b1;
        @(posedge CLK);
        rdLoad[p]   <= 1'b0;
        rdLength[p] <= burstMemPkg::lenT'(len);   // Reads start from here on
        rdStartM[p] = startA;
        rdMaxM[p]   = maxA;
        rdLenM[p]   = len;
        rdPtrM[p]   = startA;
        rdBeat[p]   = 0;
    endtask

    // Arbiter idle for QUIET cycles in a row
    task automatic waitIdle();
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while (quiet < QUIET && cycles < TIMEOUT)
        begin
            @(posedge CLK);
            cycles++;
            if (UUT.uArbiter.busy || UUT.uArbiter.start)
                quiet = 0;
            else
                quiet++;
        end
        if (quiet < QUIET)
        begin
            $display("Timeout at %0t ns: the arbiter never went idle", $time);
            errors++;
        end
    endtask

    // Stop both read ports and drop their prefetched words
    task automatic endReads();
        @(posedge CLK);
        rdLength[0] <= '0;
        rdLength[1] <= '0;
        waitIdle();
        rdLoad[0] <= 1'b1;
        rdLoad[1] <= 1'b1;
        @(posedge CLK);
        rdLoad[0] <= 1'b0;
        rdLoad[1] <= 1'b0;
    endtask

    // One random word into each enabled write FIFO in the same cycle
    task automatic pushWords(input logic en0, input logic en1);
        int                cycles;
        burstMemPkg::dataT word;
        cycles = 0;
        @(posedge CLK);
        while (((en0 && wrFull[0]) || (en1 && wrFull[1])) && cycles < TIMEOUT)
        begin
            @(posedge CLK);
            cycles++;
        end
        if ((en0 && wrFull[0]) || (en1 && wrFull[1]))
        begin
            $display("Timeout at %0t ns: a write FIFO stayed full", $time);
            errors++;
            return;
        end
        if (en0)
        begin
            word = burstMemPkg::dataT'($random(seed));
            wrData[0] <= word;
            wrPush[0] <= 1'b1;
            recordPush(1'b0, word);
        end
        if (en1)
        begin
            word = burstMemPkg::dataT'($random(seed));
            wrData[1] <= word;
            wrPush[1] <= 1'b1;
            recordPush(1'b1, word);
        end
        @(posedge CLK);
        wrPush[0] <= 1'b0;
        wrPush[1] <= 1'b0;
    endtask

    // Pop n words and compare each head with the model in address order
    task automatic readWords(input logic p, input int n);
        int                cycles;
        burstMemPkg::dataT expected;
        for (int i = 0; i < n; i++)
        begin
            cycles = 0;
            @(posedge CLK);
            while (rdEmpty[p] && cycles < TIMEOUT)
            begin
                @(posedge CLK);
                cycles++;
            end
            if (rdEmpty[p])
            begin
                $display("Timeout at %0t ns: read FIFO %0d never got data", $time, p);
                errors++;
                return;
            end
            expected = modelMem[burstMemPkg::addrT'(rdPtrM[p] + rdBeat[p])];
            checks++;
            assert (rdData[p] == expected)
            else
            begin
                $display("** Error at %0t ns: rdData[%0d] = 0x%h, expected 0x%h",
                         $time, p, rdData[p], expected);
                errors++;
            end
            rdBeat[p]++;
            if (rdBeat[p] == rdLenM[p])
            begin
                rdPtrM[p] = advancePointer(rdPtrM[p], rdLenM[p], rdStartM[p], rdMaxM[p]);
                rdBeat[p] = 0;
            end
            rdPop[p] <= 1'b1;
            @(posedge CLK);
            rdPop[p] <= 1'b0;
        end
    endtask

    task automatic endTest(input string name);
        $display("Test %s: %0d errors", name, errors - testErrors);
        testErrors = errors;
    endtask

    //============================================================
    // Test sequence
    //============================================================
    initial
    begin
        seed       = 69;
        errors     = 0;
        checks     = 0;
        testErrors = 0;
        CLK        = 1'b0;
        RESET_N    = 1'b0;
        for (int i = 0; i < `BM_NUM_WR; i++)
        begin
            wrData[i]   = '0;
            wrPush[i]   = 1'b0;
            wrLoad[i]   = 1'b0;
            wrStart[i]  = '0;
            wrMax[i]    = '0;
            wrLength[i] = '0;      // Idle until configured
            pendCount[i] = 0;
        end
        for (int i = 0; i < `BM_NUM_RD; i++)
        begin
            rdPop[i]    = 1'b0;
            rdLoad[i]   = 1'b0;
            rdStart[i]  = '0;
            rdMax[i]    = '0;
            rdLength[i] = '0;
        end
        repeat (2) @(posedge CLK);
        RESET_N <= 1'b1;
        @(posedge CLK);

        for (int i = 0; i < `BM_NUM_RD; i++)
        begin
            checks++;
            assert (rdEmpty[i] == 1'b1)
            else
            begin
                $display("** Error at %0t ns: rdEmpty[%0d] = %b, expected 1",
                         $time, i, rdEmpty[i]);
                errors++;
            end
        end
        for (int i = 0; i < `BM_NUM_WR; i++)
        begin
            checks++;
            assert (wrFull[i] == 1'b0)
            else
            begin
                $display("** Error at %0t ns: wrFull[%0d] = %b, expected 0",
                         $time, i, wrFull[i]);
                errors++;
            end
        end
        endTest("1 reset state");

        configWrite(1'b0, 16, 47, 4);
        repeat (32) pushWords(1'b1, 1'b0);
        waitIdle();
        configRead(1'b0, 16, 47, 4);
        readWords(1'b0, 32);
        endReads();
        endTest("2 write then read back");

        // Disjoint windows with both ports filled in the same cycles
        configWrite(1'b0, 64, 95, 4);
        configWrite(1'b1, 128, 159, 8);
        repeat (16) pushWords(1'b1, 1'b1);
        waitIdle();
        configRead(1'b0, 64, 95, 4);
        configRead(1'b1, 128, 159, 8);
        readWords(1'b0, 16);
        readWords(1'b1, 16);
        endReads();
        endTest("3 both write ports");

        // Window two words longer than four bursts
        configWrite(1'b0, 200, 217, 4);
        repeat (24) pushWords(1'b1, 1'b0);   // Six bursts into four slots
        waitIdle();
        configRead(1'b0, 200, 217, 4);
        readWords(1'b0, 16);
        endReads();
        endTest("4 address wrap");

        configWrite(1'b1, 160, 175, 4);
        repeat (2) pushWords(1'b0, 1'b1);    // Short of a burst
        waitIdle();
        configWrite(1'b1, 160, 175, 4);      // Load pulse
        repeat (4) pushWords(1'b0, 1'b1);
        waitIdle();
        configRead(1'b1, 160, 175, 4);
        readWords(1'b1, 4);
        endReads();
        endTest("5 load clears FIFO");

        $display("Tests: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+rtl
rtl/burstMemPkg.sv
rtl/portFifo.sv
rtl/burstArbiter.sv
rtl/burstSequencer.sv
rtl/wordMemory.sv
rtl/burstMemTop.sv
testbench/burstMemTb.sv
